// ==== common/vdc_pkg.sv ====
/*
 * VDC shared definitions
 * Widths, register indices, control and position structs and the
 * horizontal phase encoding used across the text display controller
 */
package vdc_pkg;

	localparam int VRAM_ADDR_BITS = 15;           // 32K bytes of video memory

	typedef logic [7:0]                byte_t;    // Bus data and register value
	typedef logic [VRAM_ADDR_BITS-1:0] vaddr_t;   // Video memory address
	typedef logic [5:0]                reg_idx_t; // Internal register index
	typedef logic [3:0]                rgbi_t;    // Output colour

	localparam reg_idx_t R_HT    = 6'd0;          // Horizontal total - 1
	localparam reg_idx_t R_HD    = 6'd1;          // Characters displayed
	localparam reg_idx_t R_HP    = 6'd2;          // Hsync start character
	localparam reg_idx_t R_SYNCW = 6'd3;          // Vsync width / hsync width
	localparam reg_idx_t R_VT    = 6'd4;          // Vertical total - 1
	localparam reg_idx_t R_VD    = 6'd6;          // Rows displayed
	localparam reg_idx_t R_VP    = 6'd7;          // Vsync start row
	localparam reg_idx_t R_CTV   = 6'd9;          // Scanlines per row - 1
	localparam reg_idx_t R_DSH   = 6'd12;         // Display start high
	localparam reg_idx_t R_DSL   = 6'd13;         // Display start low
	localparam reg_idx_t R_LPV   = 6'd16;         // Light pen row
	localparam reg_idx_t R_LPH   = 6'd17;         // Light pen column
	localparam reg_idx_t R_UAH   = 6'd18;         // Update address high
	localparam reg_idx_t R_UAL   = 6'd19;         // Update address low
	localparam reg_idx_t R_MODE  = 6'd24;         // Bit 6 reverse screen
	localparam reg_idx_t R_COLOR = 6'd26;         // Foreground / background
	localparam reg_idx_t R_CB    = 6'd28;         // Character set base
	localparam reg_idx_t R_DATA  = 6'd31;         // Video memory data

	typedef struct packed {
		byte_t      ht;                           // Horizontal total - 1
		byte_t      hd;                           // Characters displayed
		byte_t      hp;                           // Hsync start
		logic [3:0] vw;                           // Vsync width in scanlines
		logic [3:0] hw;                           // Hsync width in characters
		byte_t      vt;                           // Vertical total - 1
		byte_t      vd;                           // Rows displayed
		byte_t      vp;                           // Vsync start row
		logic [4:0] ctv;                          // Scanlines per row - 1
		vaddr_t     ds;                           // Display start address
		logic       rvs;                          // Reverse screen
		rgbi_t      fg;                           // Foreground colour
		rgbi_t      bg;                           // Background colour
		logic [2:0] cb;                           // Character set base, 4K steps
	} ctrl_t;

	typedef struct packed {
		byte_t      col;                          // Character column
		logic [2:0] pix;                          // Pixel within character
		logic [4:0] line;                         // Scanline within row
		byte_t      row;                          // Character row
		logic       visible;                      // Inside display window
		logic       hsync;
		logic       vsync;
		logic       blank;                        // Horizontal blank
	} pos_t;

	// Blanked position with everything else idle, used out of reset
	localparam pos_t POS_IDLE = '{col: '0, pix: '0, line: '0, row: '0,
		visible: 1'b0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

	typedef enum logic [1:0] {
		DISPLAY,                                  // Active characters
		BORDER,                                   // Blanked, outside sync
		SYNC                                      // Horizontal sync pulse
	} tstate_t;

endpackage

// ==== design/vdc_regs.sv ====
/*
 * VDC host register file
 * Index register plus the internal display registers on a two-address bus,
 * read decode with one-filled unused bits, the update address with
 * post-increment feeding the video memory write port, and the light pen
 */
`timescale 1ns/1ps

module vdc_regs (
	input  logic             clk,
	input  logic             reset,
	input  logic             cs,
	input  logic             rs,
	input  logic             we,
	input  vdc_pkg::byte_t   db_in,
	input  logic             lp,
	input  vdc_pkg::pos_t    pos,
	output vdc_pkg::byte_t   db_out,
	output vdc_pkg::ctrl_t   ctrl,
	output logic             vram_we,
	output vdc_pkg::vaddr_t  vram_waddr,
	output vdc_pkg::byte_t   vram_wdata
);

	vdc_pkg::reg_idx_t idx;                   // Selected register
	vdc_pkg::vaddr_t   ua;                    // Update address
	vdc_pkg::byte_t    lpv;                   // Latched light pen row
	vdc_pkg::byte_t    lph;                   // Latched light pen column
	vdc_pkg::byte_t    rd_data;
	logic              lp_flag;
	logic [2:0]        lp_sync;               // Two sync flops plus edge history
	logic              lp_rise;
	logic              wr_reg;
	logic              rd_lp;

	assign wr_reg  = cs && we && rs;
	assign lp_rise = lp_sync[1] && !lp_sync[2];
	assign rd_lp   = cs && !we && rs && (idx == vdc_pkg::R_LPV || idx == vdc_pkg::R_LPH);

	// Read decode
	always_comb begin
		if (!rs) begin
			rd_data = {1'b1, lp_flag, pos.row >= ctrl.vd, 5'b00000}; // Status, never busy
		end else begin
			case (idx)
				vdc_pkg::R_HT:    rd_data = ctrl.ht;
				vdc_pkg::R_HD:    rd_data = ctrl.hd;
				vdc_pkg::R_HP:    rd_data = ctrl.hp;
				vdc_pkg::R_SYNCW: rd_data = {ctrl.vw, ctrl.hw};
				vdc_pkg::R_VT:    rd_data = ctrl.vt;
				vdc_pkg::R_VD:    rd_data = ctrl.vd;
				vdc_pkg::R_VP:    rd_data = ctrl.vp;
				vdc_pkg::R_CTV:   rd_data = {3'b111, ctrl.ctv};
				vdc_pkg::R_DSH:   rd_data = {1'b1, ctrl.ds[14:8]};   // 15-bit address space
				vdc_pkg::R_DSL:   rd_data = ctrl.ds[7:0];
				vdc_pkg::R_LPV:   rd_data = lpv;
				vdc_pkg::R_LPH:   rd_data = lph;
				vdc_pkg::R_UAH:   rd_data = {1'b1, ua[14:8]};
				vdc_pkg::R_UAL:   rd_data = ua[7:0];
				vdc_pkg::R_MODE:  rd_data = {1'b1, ctrl.rvs, 6'b111111};
				vdc_pkg::R_COLOR: rd_data = {ctrl.fg, ctrl.bg};
				vdc_pkg::R_CB:    rd_data = {ctrl.cb, 5'b11111};
				vdc_pkg::R_DATA:  rd_data = vram_wdata;           // Last byte written
				default:          rd_data = 8'hff;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idx        <= '0;
			ctrl       <= '0;
			ua         <= '0;
			vram_we    <= 1'b0;
			vram_wdata <= '0;
			db_out     <= '0;
			lpv        <= '0;
			lph        <= '0;
			lp_flag    <= 1'b0;
			lp_sync    <= '0;
		end else begin
			vram_we <= 1'b0;                      // Single-cycle strobe
			lp_sync <= {lp_sync[1:0], lp};
			if (cs && we && !rs)
				idx <= db_in[5:0];
			if (wr_reg) begin
				case (idx)
					vdc_pkg::R_HT:    ctrl.ht <= db_in;
					vdc_pkg::R_HD:    ctrl.hd <= db_in;
					vdc_pkg::R_HP:    ctrl.hp <= db_in;
					vdc_pkg::R_SYNCW: begin
						ctrl.vw <= db_in[7:4];
						ctrl.hw <= db_in[3:0];
					end
					vdc_pkg::R_VT:    ctrl.vt <= db_in;
					vdc_pkg::R_VD:    ctrl.vd <= db_in;
					vdc_pkg::R_VP:    ctrl.vp <= db_in;
					vdc_pkg::R_CTV:   ctrl.ctv <= db_in[4:0];
					vdc_pkg::R_DSH:   ctrl.ds[14:8] <= db_in[6:0];
					vdc_pkg::R_DSL:   ctrl.ds[7:0] <= db_in;
					vdc_pkg::R_UAH:   ua[14:8] <= db_in[6:0];
					vdc_pkg::R_UAL:   ua[7:0] <= db_in;
					vdc_pkg::R_MODE:  ctrl.rvs <= db_in[6];
					vdc_pkg::R_COLOR: begin
						ctrl.fg <= db_in[7:4];
						ctrl.bg <= db_in[3:0];
					end
					vdc_pkg::R_CB:    ctrl.cb <= db_in[7:5];
					vdc_pkg::R_DATA:  begin
						vram_wdata <= db_in;
						vram_we    <= 1'b1;       // Memory write lands next cycle
						ua         <= ua + 1'b1;  // Post-increment
					end
					default: ;                    // Read-only or unimplemented
				endcase
			end
			if (cs && !we)
				db_out <= rd_data;                // Held until the next read
			if (rd_lp)
				lp_flag <= 1'b0;
			if (lp_rise && !lp_flag) begin       // First edge wins until read
				lpv     <= pos.row;
				lph     <= pos.col;
				lp_flag <= 1'b1;
			end
		end
	end

	// Write address is the update address before the increment
	always_ff @(posedge clk) begin
		if (wr_reg && idx == vdc_pkg::R_DATA)
			vram_waddr <= ua;
	end

endmodule

// ==== design/vdc_timing.sv ====
/*
 * VDC raster timing
 * Pixel, column, scanline and row counters wrapping on the totals,
 * horizontal phase FSM for display, border and hsync, plus vsync
 * and the visible window
 */
`timescale 1ns/1ps

module vdc_timing (
	input  logic           clk,
	input  logic           reset,
	input  vdc_pkg::ctrl_t ctrl,
	output vdc_pkg::pos_t  pos
);

	logic [2:0]       pix;
	vdc_pkg::byte_t   col;
	logic [4:0]       line;
	vdc_pkg::byte_t   row;
	logic [3:0]       vs_cnt;                 // Scanlines of vsync left
	vdc_pkg::tstate_t hstate;
	vdc_pkg::tstate_t hstate_nxt;
	vdc_pkg::byte_t   col_nxt;
	logic [4:0]       line_nxt;
	vdc_pkg::byte_t   row_nxt;
	logic [8:0]       sync_off;               // Characters since hsync start
	logic             in_sync;
	logic             end_char;
	logic             end_line;
	logic             end_row;

	always_comb begin
		end_char = pix == 3'd7;
		end_line = end_char && col >= ctrl.ht;
		end_row  = end_line && line >= ctrl.ctv;
		col_nxt  = (col >= ctrl.ht) ? '0 : col + 1'b1;
		line_nxt = (line >= ctrl.ctv) ? '0 : line + 1'b1;
		row_nxt  = (row >= ctrl.vt) ? '0 : row + 1'b1;
		sync_off = {1'b0, col_nxt} - {1'b0, ctrl.hp};
		in_sync  = col_nxt >= ctrl.hp && sync_off < {5'b00000, ctrl.hw};
	end

	// Phase of the character about to start
	always_comb begin
		hstate_nxt = hstate;
		case (hstate)
			vdc_pkg::DISPLAY:
				if (col_nxt >= ctrl.hd)
					hstate_nxt = in_sync ? vdc_pkg::SYNC : vdc_pkg::BORDER;
			vdc_pkg::BORDER:
				if (col_nxt < ctrl.hd)
					hstate_nxt = vdc_pkg::DISPLAY;    // New line starts
				else if (in_sync)
					hstate_nxt = vdc_pkg::SYNC;
			vdc_pkg::SYNC:
				if (col_nxt < ctrl.hd)
					hstate_nxt = vdc_pkg::DISPLAY;
				else if (!in_sync)
					hstate_nxt = vdc_pkg::BORDER;     // Width used up
			default: hstate_nxt = vdc_pkg::BORDER;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pix    <= '0;
			col    <= '0;
			line   <= '0;
			row    <= '0;
			vs_cnt <= '0;
			hstate <= vdc_pkg::BORDER;            // Nothing displayed with zeroed registers
		end else begin
			pix <= pix + 1'b1;                    // 8 pixels per character
			if (end_char) begin
				col    <= col_nxt;
				hstate <= hstate_nxt;
			end
			if (end_line)
				line <= line_nxt;
			if (end_row)
				row <= row_nxt;
			if (end_row && row_nxt == ctrl.vp)
				vs_cnt <= ctrl.vw;                // Vsync from first scanline of vp
			else if (end_line && vs_cnt != '0)
				vs_cnt <= vs_cnt - 1'b1;
		end
	end

	always_comb begin
		pos.col     = col;
		pos.pix     = pix;
		pos.line    = line;
		pos.row     = row;
		pos.visible = hstate == vdc_pkg::DISPLAY && row < ctrl.vd;
		pos.hsync   = hstate == vdc_pkg::SYNC;
		pos.vsync   = vs_cnt != '0;
		pos.blank   = hstate != vdc_pkg::DISPLAY;
	end

endmodule

// ==== vdc_fetch/vdc_vram.sv ====
/*
 * VDC video memory
 * 32K bytes with a host write port and two registered read ports,
 * A for screen codes and B for glyph rows
 */
`timescale 1ns/1ps

module vdc_vram (
	input  logic            clk,
	input  logic            we,
	input  vdc_pkg::vaddr_t waddr,
	input  vdc_pkg::byte_t  wdata,
	input  vdc_pkg::vaddr_t raddr_a,
	input  vdc_pkg::vaddr_t raddr_b,
	output vdc_pkg::byte_t  rdata_a,
	output vdc_pkg::byte_t  rdata_b
);

	vdc_pkg::byte_t mem [2**vdc_pkg::VRAM_ADDR_BITS];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Old data on a same-cycle read and write
	always_ff @(posedge clk) begin
		rdata_a <= mem[raddr_a];              // Screen code
		rdata_b <= mem[raddr_b];              // Glyph row
	end

endmodule

// ==== vdc_fetch/vdc_fetch.sv ====
/*
 * VDC character fetch
 * Cycle 1 addresses the screen code, cycle 2 addresses its glyph row;
 * the video memory read registers act as the stage boundaries and the
 * position travels alongside so it meets its glyph
 */
`timescale 1ns/1ps

module vdc_fetch (
	input  logic            clk,
	input  logic            reset,
	input  vdc_pkg::ctrl_t  ctrl,
	input  vdc_pkg::pos_t   pos_in,
	input  vdc_pkg::byte_t  code,
	input  vdc_pkg::byte_t  glyph,
	output vdc_pkg::vaddr_t scr_addr,
	output vdc_pkg::vaddr_t chr_addr,
	output vdc_pkg::byte_t  glyph_out,
	output vdc_pkg::pos_t   pos_out
);

	vdc_pkg::pos_t   pos_d1;                  // Matches code
	vdc_pkg::pos_t   pos_d2;                  // Matches glyph
	logic [15:0]     row_base;                // row * characters per line
	vdc_pkg::vaddr_t cb_base;
	vdc_pkg::vaddr_t code_off;

	// Stage 1, screen code address
	always_comb begin
		row_base = pos_in.row * ctrl.hd;
		scr_addr = ctrl.ds
			+ vdc_pkg::vaddr_t'(row_base)
			+ vdc_pkg::vaddr_t'(pos_in.col);      // Wraps in 32K
	end

	// Stage 2, glyph row address, 16 bytes per character
	always_comb begin
		cb_base  = {ctrl.cb, 12'h000};
		code_off = {3'b000, code, 4'h0};
		chr_addr = cb_base + code_off + vdc_pkg::vaddr_t'(pos_d1.line);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos_d1 <= vdc_pkg::POS_IDLE;
			pos_d2 <= vdc_pkg::POS_IDLE;
		end else begin
			pos_d1 <= pos_in;
			pos_d2 <= pos_d1;
		end
	end

	assign glyph_out = glyph;                 // Glyph byte already registered by memory
	assign pos_out   = pos_d2;

endmodule

// ==== design/vdc_pixel.sv ====
/*
 * VDC pixel stage
 * Selects the glyph bit for the current pixel, applies reverse and
 * the colour registers, and registers sync and blank with the colour
 */
`timescale 1ns/1ps

module vdc_pixel (
	input  logic           clk,
	input  logic           reset,
	input  vdc_pkg::ctrl_t ctrl,
	input  vdc_pkg::byte_t glyph,
	input  vdc_pkg::pos_t  pos,
	output vdc_pkg::rgbi_t rgbi,
	output logic           hsync,
	output logic           vsync,
	output logic           hblank,
	output logic           vblank
);

	logic           bit_on;
	logic           vb;                       // Outside vertical display
	logic           show;
	vdc_pkg::rgbi_t colour;

	always_comb begin
		bit_on = glyph[3'd7 - pos.pix] ^ ctrl.rvs;     // MSB is leftmost
		vb     = pos.row >= ctrl.vd;
		show   = pos.visible;                          // Display window from timing
		colour = bit_on ? ctrl.fg : ctrl.bg;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rgbi   <= '0;
			hsync  <= 1'b0;
			vsync  <= 1'b0;
			hblank <= 1'b1;
			vblank <= 1'b1;
		end else begin
			rgbi   <= show ? colour : '0;          // Black in blanking
			hsync  <= pos.hsync;
			vsync  <= pos.vsync;
			hblank <= pos.blank;
			vblank <= vb;
		end
	end

endmodule

// ==== design/vdc_top.sv ====
/*
 * VDC top level
 * Register file beside a timing, fetch and pixel pipeline
 * sharing the video memory
 */
`timescale 1ns/1ps

module vdc_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           cs,
	input  logic           rs,
	input  logic           we,
	input  vdc_pkg::byte_t db_in,
	input  logic           lp,
	output vdc_pkg::byte_t db_out,
	output vdc_pkg::rgbi_t rgbi,
	output logic           hsync,
	output logic           vsync,
	output logic           hblank,
	output logic           vblank
);

	vdc_pkg::ctrl_t  ctrl;
	vdc_pkg::pos_t   pos_live;                // Timing output
	vdc_pkg::pos_t   pos_pix;                 // Position aligned with glyph
	logic            vram_we;
	vdc_pkg::vaddr_t vram_waddr;
	vdc_pkg::byte_t  vram_wdata;
	vdc_pkg::vaddr_t scr_addr;
	vdc_pkg::vaddr_t chr_addr;
	vdc_pkg::byte_t  code;
	vdc_pkg::byte_t  glyph;
	vdc_pkg::byte_t  glyph_pix;

	vdc_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.cs         (cs),
		.rs         (rs),
		.we         (we),
		.db_in      (db_in),
		.lp         (lp),
		.pos        (pos_live),
		.db_out     (db_out),
		.ctrl       (ctrl),
		.vram_we    (vram_we),
		.vram_waddr (vram_waddr),
		.vram_wdata (vram_wdata)
	);

	vdc_timing u_timing (
		.clk   (clk),
		.reset (reset),
		.ctrl  (ctrl),
		.pos   (pos_live)
	);

	vdc_fetch u_fetch (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl),
		.pos_in    (pos_live),
		.code      (code),
		.glyph     (glyph),
		.scr_addr  (scr_addr),
		.chr_addr  (chr_addr),
		.glyph_out (glyph_pix),
		.pos_out   (pos_pix)
	);

	vdc_vram u_vram (
		.clk     (clk),
		.we      (vram_we),
		.waddr   (vram_waddr),
		.wdata   (vram_wdata),
		.raddr_a (scr_addr),
		.raddr_b (chr_addr),
		.rdata_a (code),
		.rdata_b (glyph)
	);

	vdc_pixel u_pixel (
		.clk    (clk),
		.reset  (reset),
		.ctrl   (ctrl),
		.glyph  (glyph_pix),
		.pos    (pos_pix),
		.rgbi   (rgbi),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank)
	);

endmodule

// ==== testbench/vdc_assertions.sv ====
/*
 * VDC output assertions
 * Sync stays inside blanking, colour is black while blanked
 * and video memory write strobes last one cycle
 */
`timescale 1ns/1ps

module vdc_assertions (
	input logic           clk,
	input logic           reset,
	input logic           hsync,
	input logic           hblank,
	input logic           vblank,
	input vdc_pkg::rgbi_t rgbi,
	input logic           vram_we
);

	int failures = 0;                             // Assertion failure count

	a_sync_in_blank: assert property (@(posedge clk) disable iff (reset)
		hsync |-> hblank)
	else begin
		failures++;
		$error("hsync high outside horizontal blank");
	end

	// Colour path forced to black in either blank
	a_black_in_blank: assert property (@(posedge clk) disable iff (reset)
		(hblank || vblank) |-> rgbi == '0)
	else begin
		failures++;
		$error("rgbi not black while blanked");
	end

	a_we_single: assert property (@(posedge clk) disable iff (reset)
		vram_we |=> !vram_we)
	else begin
		failures++;
		$error("vram_we held longer than one cycle");
	end

endmodule

bind vdc_top vdc_assertions u_assertions (
	.clk     (clk),
	.reset   (reset),
	.hsync   (hsync),
	.hblank  (hblank),
	.vblank  (vblank),
	.rgbi    (rgbi),
	.vram_we (vram_we)
);

// ==== testbench/vdc_tb.sv ====
/*
 * VDC testbench
 * Directed tests for register readback, video memory load, raster timing,
 * glyph output with reverse screen and the light pen latch
 */
`timescale 1ns/1ps

module vdc_tb;

	localparam int CLK_PERIOD = 4;
	localparam int HT_VAL     = 9;                // Small test mode
	localparam int HD_VAL     = 4;
	localparam int HP_VAL     = 6;
	localparam int HSW_VAL    = 2;
	localparam int VT_VAL     = 3;
	localparam int VD_VAL     = 2;
	localparam int VP_VAL     = 3;
	localparam int VSW_VAL    = 1;
	localparam int CTV_VAL    = 7;
	localparam int LINE_CYC   = (HT_VAL + 1) * 8;
	localparam int FRAME_CYC  = LINE_CYC * (VT_VAL + 1) * (CTV_VAL + 1);
	localparam int WATCHDOG_CYC = 16 * FRAME_CYC; // Tests take about nine frames
	localparam vdc_pkg::vaddr_t GLYPH_BASE = 15'h1000; // Character set base 1
	localparam vdc_pkg::byte_t  CODE_ON    = 8'h01;    // All-ones glyph
	localparam vdc_pkg::byte_t  CODE_OFF   = 8'h02;    // All-zeros glyph
	localparam vdc_pkg::rgbi_t  FG         = 4'ha;
	localparam vdc_pkg::rgbi_t  BG         = 4'h5;

	logic           clk;
	logic           reset;
	logic           cs;
	logic           rs;
	logic           we;
	logic           lp;
	vdc_pkg::byte_t db_in;
	vdc_pkg::byte_t db_out;
	vdc_pkg::rgbi_t rgbi;
	logic           hsync;
	logic           vsync;
	logic           hblank;
	logic           vblank;
	int             errors = 0;
	int             seed;
	int             cycle = 0;                    // Rising edges since start
	logic [7:0]     on_map;                       // Screen cell holds CODE_ON

	vdc_top u_vdc_top (
		.clk    (clk),
		.reset  (reset),
		.cs     (cs),
		.rs     (rs),
		.we     (we),
		.db_in  (db_in),
		.lp     (lp),
		.db_out (db_out),
		.rgbi   (rgbi),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
		$display(">>> FAIL");
		$finish;
	end

	task automatic report_value(input string name, input int exp, input int act);
		errors++;
		$display("Fail %s: expected %0h, actual %0h", name, exp, act);
	endtask

	task automatic report_msg(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	// One-cycle strobe, then an idle cycle
	task automatic bus_write(input logic sel, input vdc_pkg::byte_t data);
		@(negedge clk);
		cs    = 1'b1;
		rs    = sel;
		we    = 1'b1;
		db_in = data;
		@(negedge clk);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic bus_read(input logic sel, output vdc_pkg::byte_t data);
		@(negedge clk);
		cs = 1'b1;
		rs = sel;
		we = 1'b0;
		@(negedge clk);
		cs   = 1'b0;
		data = db_out;                            // Loaded on the edge in between
	endtask

	task automatic set_reg(input vdc_pkg::reg_idx_t idx, input vdc_pkg::byte_t val);
		bus_write(1'b0, {2'b00, idx});
		bus_write(1'b1, val);
	endtask

	task automatic get_reg(input vdc_pkg::reg_idx_t idx, output vdc_pkg::byte_t val);
		bus_write(1'b0, {2'b00, idx});
		bus_read(1'b1, val);
	endtask

	// Point the update address at addr and leave the data register selected
	task automatic set_update_addr(input vdc_pkg::vaddr_t addr);
		set_reg(vdc_pkg::R_UAH, {1'b0, addr[14:8]});
		set_reg(vdc_pkg::R_UAL, addr[7:0]);
		bus_write(1'b0, {2'b00, vdc_pkg::R_DATA});
	endtask

	function automatic logic sig_value(input int sel);
		case (sel)
			0:       return hsync;
			1:       return vsync;
			default: return !hblank;                  // Display start of a line
		endcase
	endfunction

	// Returns at the negedge where the edge is first seen
	task automatic wait_edge(input int sel, input bit rise, input int limit, output int at);
		logic prev;
		logic cur;
		at   = -1;
		prev = sig_value(sel);
		for (int n = 0; n < limit; n++) begin
			@(negedge clk);
			cur = sig_value(sel);
			if (rise ? (cur && !prev) : (!cur && prev)) begin
				at = cycle;
				return;
			end
			prev = cur;
		end
		report_msg($sformatf("output %0d did not toggle within %0d cycles", sel, limit));
	endtask

	task automatic check_registers;
		vdc_pkg::reg_idx_t idx_list [15];
		vdc_pkg::byte_t    mask_list [15];
		vdc_pkg::byte_t    pat;
		vdc_pkg::byte_t    got;
		vdc_pkg::byte_t    exp;
		idx_list  = '{vdc_pkg::R_HT, vdc_pkg::R_HD, vdc_pkg::R_HP, vdc_pkg::R_SYNCW,
			vdc_pkg::R_VT, vdc_pkg::R_VD, vdc_pkg::R_VP, vdc_pkg::R_CTV, vdc_pkg::R_DSH,
			vdc_pkg::R_DSL, vdc_pkg::R_UAH, vdc_pkg::R_UAL, vdc_pkg::R_MODE,
			vdc_pkg::R_COLOR, vdc_pkg::R_CB};
		mask_list = '{8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'h1f, 8'h7f,
			8'hff, 8'h7f, 8'hff, 8'h40, 8'hff, 8'he0};   // Implemented bits
		for (int i = 0; i < 15; i++) begin
			pat = $random(seed);
			set_reg(idx_list[i], pat);
			get_reg(idx_list[i], got);
			exp = (pat & mask_list[i]) | ~mask_list[i];  // Unused bits read 1
			if (got !== exp)
				report_value($sformatf("register readback R%0d", idx_list[i]), exp, got);
		end
		get_reg(6'd5, got);
		if (got !== 8'hff)
			report_value("undefined register R5", 8'hff, got);
		get_reg(6'd40, got);
		if (got !== 8'hff)
			report_value("undefined register R40", 8'hff, got);
		bus_read(1'b0, got);
		if (got[7] !== 1'b1)
			report_value("status ready bit", 1, got[7]);
		if (got[4:0] !== 5'd0)
			report_value("status low bits", 0, got[4:0]);
	endtask

	task automatic load_video_memory;
		vdc_pkg::byte_t  data;
		vdc_pkg::byte_t  got;
		vdc_pkg::vaddr_t start;
		vdc_pkg::vaddr_t last;
		start = 15'h12fe;                         // Carries into the high byte
		set_update_addr(start);
		for (int i = 0; i < 5; i++) begin
			data = $random(seed);
			bus_write(1'b1, data);
		end
		last = start + 15'd5;
		get_reg(vdc_pkg::R_UAH, got);
		if (got !== {1'b1, last[14:8]})
			report_value("update address high", {1'b1, last[14:8]}, got);
		get_reg(vdc_pkg::R_UAL, got);
		if (got !== last[7:0])
			report_value("update address low", last[7:0], got);
		get_reg(vdc_pkg::R_DATA, got);
		if (got !== data)
			report_value("data register readback", data, got);
	endtask

	task automatic set_small_mode;
		set_reg(vdc_pkg::R_HT, HT_VAL);
		set_reg(vdc_pkg::R_HD, HD_VAL);
		set_reg(vdc_pkg::R_HP, HP_VAL);
		set_reg(vdc_pkg::R_SYNCW, {4'(VSW_VAL), 4'(HSW_VAL)});
		set_reg(vdc_pkg::R_VT, VT_VAL);
		set_reg(vdc_pkg::R_VD, VD_VAL);
		set_reg(vdc_pkg::R_VP, VP_VAL);
		set_reg(vdc_pkg::R_CTV, CTV_VAL);
		set_reg(vdc_pkg::R_DSH, 8'h00);           // Screen at address 0
		set_reg(vdc_pkg::R_DSL, 8'h00);
		set_reg(vdc_pkg::R_MODE, 8'h00);
		set_reg(vdc_pkg::R_COLOR, {FG, BG});
		set_reg(vdc_pkg::R_CB, 8'h20);            // Base 1, glyphs from 0x1000
	endtask

	task automatic measure_timing;
		int t0;
		int t1;
		int t2;
		wait_edge(0, 1'b1, 2 * FRAME_CYC, t0);    // Let the new totals settle
		wait_edge(0, 1'b1, 2 * LINE_CYC, t0);
		wait_edge(0, 1'b0, 2 * LINE_CYC, t1);
		wait_edge(0, 1'b1, 2 * LINE_CYC, t2);
		if (t1 - t0 != HSW_VAL * 8)
			report_value("hsync high time", HSW_VAL * 8, t1 - t0);
		if (t2 - t0 != LINE_CYC)
			report_value("hsync period", LINE_CYC, t2 - t0);
		wait_edge(1, 1'b1, 2 * FRAME_CYC, t0);
		wait_edge(1, 1'b1, 2 * FRAME_CYC, t0);
		wait_edge(1, 1'b0, 2 * FRAME_CYC, t1);
		wait_edge(1, 1'b1, 2 * FRAME_CYC, t2);
		if (t1 - t0 != VSW_VAL * LINE_CYC)
			report_value("vsync high time", VSW_VAL * LINE_CYC, t1 - t0);
		if (t2 - t0 != FRAME_CYC)
			report_value("vsync period", FRAME_CYC, t2 - t0);
	endtask

	task automatic setup_glyphs;
		set_update_addr(GLYPH_BASE + {3'b000, CODE_ON, 4'h0});   // 16 bytes per glyph
		repeat (16) bus_write(1'b1, 8'hff);
		set_update_addr(GLYPH_BASE + {3'b000, CODE_OFF, 4'h0});
		repeat (16) bus_write(1'b1, 8'h00);
		on_map = $random(seed);
		set_update_addr(15'h0000);
		for (int i = 0; i < HD_VAL * VD_VAL; i++)
			bus_write(1'b1, on_map[i] ? CODE_ON : CODE_OFF);   // Cell row * HD + col
	endtask

	task automatic count_glyph_pixels(input bit reverse);
		int at;
		int lines;
		int on_cnt;
		int vis_cnt;
		int ones;
		int exp;
		bit vis;
		bit was_vis;
		set_reg(vdc_pkg::R_MODE, reverse ? 8'h40 : 8'h00);
		wait_edge(1, 1'b1, 2 * FRAME_CYC, at);    // Next frame starts at row 0
		lines   = 0;
		on_cnt  = 0;
		vis_cnt = 0;
		was_vis = 1'b0;
		for (int n = 0; n < FRAME_CYC && lines < VD_VAL * (CTV_VAL + 1); n++) begin
			@(negedge clk);
			vis = !hblank && !vblank;
			if (hblank && rgbi == FG)
				report_msg("foreground colour seen during horizontal blank");
			if (vis) begin
				vis_cnt++;
				if (rgbi == FG)
					on_cnt++;
			end
			if (was_vis && !vis) begin            // End of a visible line
				ones = $countones(on_map[(lines / (CTV_VAL + 1)) * HD_VAL +: HD_VAL]);
				exp  = reverse ? (HD_VAL - ones) * 8 : ones * 8;
				if (on_cnt != exp)
					report_value($sformatf("glyph pixels line %0d", lines), exp, on_cnt);
				if (vis_cnt != HD_VAL * 8)
					report_value("visible pixels per line", HD_VAL * 8, vis_cnt);
				lines++;
				on_cnt  = 0;
				vis_cnt = 0;
			end
			was_vis = vis;
		end
		if (lines != VD_VAL * (CTV_VAL + 1))
			report_value("visible lines per frame", VD_VAL * (CTV_VAL + 1), lines);
	endtask

	task automatic exercise_light_pen;
		vdc_pkg::byte_t got;
		vdc_pkg::byte_t col;
		vdc_pkg::byte_t row;
		int             at;
		bus_read(1'b0, got);
		if (got[6] !== 1'b0)
			report_value("light pen flag before edge", 0, got[6]);
		// Edge on the first hsync cycle latches the sync start column
		wait_edge(0, 1'b1, 2 * LINE_CYC, at);
		lp = 1'b1;
		repeat (4) @(negedge clk);
		lp = 1'b0;
		bus_read(1'b0, got);
		if (got[6] !== 1'b1)
			report_value("light pen flag after edge", 1, got[6]);
		wait_edge(2, 1'b1, 2 * LINE_CYC, at);     // Second edge at column 0
		lp = 1'b1;
		repeat (4) @(negedge clk);
		lp = 1'b0;
		repeat (4) @(negedge clk);
		bus_read(1'b0, got);
		if (got[6] !== 1'b1)
			report_value("light pen flag after second edge", 1, got[6]);
		get_reg(vdc_pkg::R_LPH, col);
		if (col > HT_VAL)
			report_msg($sformatf("light pen column %0d beyond horizontal total", col));
		if (col !== HP_VAL)
			report_value("light pen column", HP_VAL, col);
		get_reg(vdc_pkg::R_LPV, row);
		if (row > VT_VAL)
			report_msg($sformatf("light pen row %0d beyond vertical total", row));
		bus_read(1'b0, got);
		if (got[6] !== 1'b0)
			report_value("light pen flag after read", 0, got[6]);
	endtask

	initial begin
		int afails;
		seed  = 32'ha0a7_9269;
		reset = 1'b1;
		cs    = 1'b0;
		rs    = 1'b0;
		we    = 1'b0;
		db_in = '0;
		lp    = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		check_registers();
		load_video_memory();
		set_small_mode();
		measure_timing();
		setup_glyphs();
		count_glyph_pixels(1'b0);
		count_glyph_pixels(1'b1);
		exercise_light_pen();
		afails = u_vdc_top.u_assertions.failures;
		$display("Result: %0d check errors, %0d assertion failures", errors, afails);
		if (errors == 0 && afails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== project.f ====
common/vdc_pkg.sv
design/vdc_regs.sv
design/vdc_timing.sv
vdc_fetch/vdc_vram.sv
vdc_fetch/vdc_fetch.sv
design/vdc_pixel.sv
design/vdc_top.sv
testbench/vdc_assertions.sv
testbench/vdc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = vdc_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUNFLAGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
